/* src/fetch_pkg.sv */
// instruction stream types
package fetch_pkg;

   typedef logic [7:0]   byte_t;
   // byte k in bits 8k+7:8k, byte 0 at the lowest address
   typedef logic [127:0] line_t;
   typedef logic [31:0]  addr_t;
   typedef logic [15:0]  seg_t;
   typedef logic [3:0]   instr_len_t;

   localparam int LINE_BYTES = 16;

   // jump or exception target
   typedef struct packed {
      logic  strobe;
      seg_t  cs;
      addr_t eip;
   } redirect_t;

   // decoder took len bytes
   typedef struct packed {
      logic       strobe;
      instr_len_t len;
   } consume_t;

   typedef struct packed {
      logic  valid;
      line_t bytes;
      addr_t eip;
   } fetch_window_t;

   typedef enum logic [1:0] {
      FILL_IDLE,
      FILL_REQ,
      FILL_DROP,
      FILL_FULL
   } fill_state_t;

endpackage

/* src/icache_pkg.sv */
// instruction cache port
package icache_pkg;

   // en and addr held until ready
   typedef struct packed {
      logic             en;
      fetch_pkg::addr_t addr;
   } icache_req_t;

   // data is valid in the ready cycle
   typedef struct packed {
      logic             ready;
      fetch_pkg::line_t data;
   } icache_rsp_t;

endpackage

/* src/fetch_line_slot.sv */
// fetch buffer line slot
`timescale 1ns/1ns

module fetch_line_slot (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             write,
   input  logic             release_line,
   input  logic             flush,
   input  fetch_pkg::line_t line_in,
   output fetch_pkg::line_t line,
   output logic             valid
);

   // flush beats both write and release
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid <= 1'b0;
      end else if (flush) begin
         valid <= 1'b0;
      end else if (write) begin
         valid <= 1'b1;
      end else if (release_line) begin
         valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (write) begin
         line <= line_in;
      end
   end

endmodule

/* src/fetch_fill_ctrl.sv */
// fetch buffer fill controller
`timescale 1ns/1ns

module fetch_fill_ctrl #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  fetch_pkg::redirect_t     redirect,
   input  logic [NUM_SLOTS-1:0]     slot_valid,
   output icache_pkg::icache_req_t  icache_req,
   input  icache_pkg::icache_rsp_t  icache_rsp,
   output logic [NUM_SLOTS-1:0]     slot_write,
   output fetch_pkg::line_t         slot_line,
   output logic                     slot_flush
);

   localparam int SLOT_W = $clog2(NUM_SLOTS);

   fetch_pkg::fill_state_t state;
   fetch_pkg::fill_state_t state_nxt;
   fetch_pkg::addr_t       fetch_addr;
   fetch_pkg::addr_t       linear_addr;
   logic [SLOT_W-1:0]      wr_slot;
   logic [SLOT_W-1:0]      wr_slot_inc;
   logic                   accept;
   logic                   pending;

   // CS * 65536 + EIP
   assign linear_addr = {redirect.cs, 16'h0000} + redirect.eip;
   assign wr_slot_inc = wr_slot + 1'b1;

   // a live request gets its line this cycle
   assign accept  = (state == fetch_pkg::FILL_REQ) && icache_rsp.ready;
   // a request still out after this cycle
   assign pending = ((state == fetch_pkg::FILL_REQ) || (state == fetch_pkg::FILL_DROP)) &&
                    !icache_rsp.ready;

   assign icache_req = '{en: (state == fetch_pkg::FILL_REQ), addr: fetch_addr};

   assign slot_line  = icache_rsp.data;
   assign slot_flush = redirect.strobe;

   always_comb begin
      slot_write = '0;
      if (accept && !redirect.strobe) begin
         slot_write[wr_slot] = 1'b1;
      end
   end

   always_comb begin
      state_nxt = state;
      unique case (state)
         fetch_pkg::FILL_IDLE: begin
            state_nxt = fetch_pkg::FILL_IDLE;
         end
         fetch_pkg::FILL_REQ: begin
            // stop if the slot after this one still holds a line
            if (icache_rsp.ready) begin
               state_nxt = slot_valid[wr_slot_inc] ? fetch_pkg::FILL_FULL : fetch_pkg::FILL_REQ;
            end
         end
         fetch_pkg::FILL_DROP: begin
            // stale line is swallowed here
            if (icache_rsp.ready) begin
               state_nxt = fetch_pkg::FILL_REQ;
            end
         end
         fetch_pkg::FILL_FULL: begin
            if (!slot_valid[wr_slot]) begin
               state_nxt = fetch_pkg::FILL_REQ;
            end
         end
         default: begin
            state_nxt = fetch_pkg::FILL_IDLE;
         end
      endcase
      if (redirect.strobe) begin
         state_nxt = pending ? fetch_pkg::FILL_DROP : fetch_pkg::FILL_REQ;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= fetch_pkg::FILL_IDLE;
         wr_slot    <= '0;
         fetch_addr <= '0;
      end else begin
         state <= state_nxt;
         if (redirect.strobe) begin
            wr_slot    <= '0;
            fetch_addr <= linear_addr;
         end else if (accept) begin
            wr_slot    <= wr_slot_inc;
            fetch_addr <= fetch_addr + fetch_pkg::addr_t'(fetch_pkg::LINE_BYTES);
         end
      end
   end

endmodule

/* src/fetch_window_align.sv */
// instruction window aligner
`timescale 1ns/1ns

module fetch_window_align #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  fetch_pkg::redirect_t     redirect,
   input  fetch_pkg::consume_t      consume,
   input  fetch_pkg::line_t         slot_line [NUM_SLOTS],
   input  logic [NUM_SLOTS-1:0]     slot_valid,
   output logic [NUM_SLOTS-1:0]     slot_release,
   output fetch_pkg::fetch_window_t window
);

   localparam int SLOT_W     = $clog2(NUM_SLOTS);
   localparam int OFF_W      = $clog2(fetch_pkg::LINE_BYTES);
   localparam int POS_W      = SLOT_W + OFF_W;
   localparam int RING_BYTES = NUM_SLOTS * fetch_pkg::LINE_BYTES;

   logic [POS_W-1:0]  rd_pos;
   logic [POS_W-1:0]  rd_pos_nxt;
   logic [SLOT_W-1:0] rd_slot;
   logic [SLOT_W-1:0] rd_slot_inc;
   logic [OFF_W-1:0]  rd_off;
   logic              take;
   logic              win_valid;
   fetch_pkg::addr_t  eip;
   fetch_pkg::line_t  win_bytes;
   fetch_pkg::byte_t  ring [RING_BYTES];

   assign rd_slot     = rd_pos[POS_W-1:OFF_W];
   assign rd_off      = rd_pos[OFF_W-1:0];
   assign rd_slot_inc = rd_slot + 1'b1;
   assign rd_pos_nxt  = rd_pos + POS_W'(consume.len);

   // redirect wins over consume
   assign take = consume.strobe && !redirect.strobe;

   // an unaligned window spills into the next slot
   assign win_valid = slot_valid[rd_slot] && ((rd_off == '0) || slot_valid[rd_slot_inc]);

   assign window = '{valid: win_valid, bytes: win_bytes, eip: eip};

   // slots laid end to end as one byte ring
   always_comb begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
         for (int k = 0; k < fetch_pkg::LINE_BYTES; k++) begin
            ring[s*fetch_pkg::LINE_BYTES + k] = slot_line[s][8*k +: 8];
         end
      end
   end

   // 16 bytes from the read position, wrapping at the ring end
   always_comb begin : win_build
      logic [POS_W-1:0] pos;
      for (int j = 0; j < fetch_pkg::LINE_BYTES; j++) begin
         pos = rd_pos + POS_W'(j);
         win_bytes[8*j +: 8] = ring[pos];
      end
   end

   // len is below 16, so at most one slot is left per consume
   always_comb begin
      slot_release = '0;
      if (take && (rd_pos_nxt[POS_W-1:OFF_W] != rd_slot)) begin
         slot_release[rd_slot] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pos <= '0;
         eip    <= '0;
      end else if (redirect.strobe) begin
         rd_pos <= '0;
         eip    <= redirect.eip;
      end else if (take) begin
         rd_pos <= rd_pos_nxt;
         eip    <= eip + fetch_pkg::addr_t'(consume.len);
      end
   end

endmodule

/* src/fetch_unit.sv */
// instruction fetch unit
`timescale 1ns/1ns

module fetch_unit #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  fetch_pkg::redirect_t     redirect,
   input  fetch_pkg::consume_t      consume,
   output icache_pkg::icache_req_t  icache_req,
   input  icache_pkg::icache_rsp_t  icache_rsp,
   output fetch_pkg::fetch_window_t window
);

   logic [NUM_SLOTS-1:0] slot_write;
   logic [NUM_SLOTS-1:0] slot_release;
   logic [NUM_SLOTS-1:0] slot_valid;
   logic                 slot_flush;
   fetch_pkg::line_t     wr_line;
   fetch_pkg::line_t     slot_lines [NUM_SLOTS];

   fetch_fill_ctrl #(
      .NUM_SLOTS (NUM_SLOTS)
   ) u_fill_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .redirect   (redirect),
      .slot_valid (slot_valid),
      .icache_req (icache_req),
      .icache_rsp (icache_rsp),
      .slot_write (slot_write),
      .slot_line  (wr_line),
      .slot_flush (slot_flush)
   );

   // line buffer ring
   for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
      fetch_line_slot u_slot (
         .clk          (clk),
         .arst_n       (arst_n),
         .write        (slot_write[g]),
         .release_line (slot_release[g]),
         .flush        (slot_flush),
         .line_in      (wr_line),
         .line         (slot_lines[g]),
         .valid        (slot_valid[g])
      );
   end

   fetch_window_align #(
      .NUM_SLOTS (NUM_SLOTS)
   ) u_align (
      .clk          (clk),
      .arst_n       (arst_n),
      .redirect     (redirect),
      .consume      (consume),
      .slot_line    (slot_lines),
      .slot_valid   (slot_valid),
      .slot_release (slot_release),
      .window       (window)
   );

endmodule

/* testbench/fetch_unit_checker.sv */
// fetch unit port assertions
`timescale 1ns/1ns

module fetch_unit_checker (
   input logic                     clk,
   input logic                     arst_n,
   input fetch_pkg::redirect_t     redirect,
   input fetch_pkg::consume_t      consume,
   input icache_pkg::icache_req_t  icache_req,
   input icache_pkg::icache_rsp_t  icache_rsp,
   input fetch_pkg::fetch_window_t window
);

   int assert_fails = 0;

   // request held until ready, a redirect may drop it
   req_stable: assert property (@(posedge clk) disable iff (!arst_n)
      icache_req.en && !icache_rsp.ready && !redirect.strobe |=>
      icache_req.en && $stable(icache_req.addr))
   else begin
      assert_fails++;
      $error("cache request dropped or changed before ready");
   end

   consume_valid: assert property (@(posedge clk) disable iff (!arst_n)
      consume.strobe |-> window.valid)
   else begin
      assert_fails++;
      $error("consume without a valid window");
   end

   consume_len: assert property (@(posedge clk) disable iff (!arst_n)
      consume.strobe |-> consume.len != '0)
   else begin
      assert_fails++;
      $error("consume with zero length");
   end

   // old lines gone one cycle after a redirect
   redirect_clear: assert property (@(posedge clk) disable iff (!arst_n)
      redirect.strobe |=> !window.valid)
   else begin
      assert_fails++;
      $error("window valid right after a redirect");
   end

endmodule

bind fetch_unit fetch_unit_checker u_checker (.*);

/* testbench/fetch_unit_tb.sv */
// fetch unit testbench
`timescale 1ns/1ns

module fetch_unit_tb;

   localparam int NUM_SLOTS = 4;
   localparam int MEM_BYTES = 4096;

   typedef struct packed {
      fetch_pkg::seg_t             cs;
      fetch_pkg::addr_t            eip;
      logic [7:0]                  stall;
      logic                        decoy;
      logic [3:0]                  count;
      fetch_pkg::instr_len_t [7:0] len;
      fetch_pkg::addr_t            final_eip;
   } test_t;

   logic                     clk;
   logic                     arst_n;
   fetch_pkg::redirect_t     redirect;
   fetch_pkg::consume_t      consume;
   icache_pkg::icache_req_t  icache_req;
   icache_pkg::icache_rsp_t  icache_rsp;
   fetch_pkg::fetch_window_t window;

   fetch_pkg::byte_t mem [MEM_BYTES];
   test_t            tests [$];
   int               seed = 32'h40f9_8032;
   int               error_count = 0;
   int               test_errors = 0;
   int               consumed_bytes = 0;
   int               accepted = 0;
   fetch_pkg::addr_t expected_addr = '0;
   bit               loaded = 1'b0;

   fetch_unit #(.NUM_SLOTS(NUM_SLOTS)) DUT (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   // linear address is CS * 65536 + EIP
   function automatic fetch_pkg::addr_t linear(input fetch_pkg::seg_t cs,
                                                input fetch_pkg::addr_t eip);
      return fetch_pkg::addr_t'(cs) * 32'd65536 + eip;
   endfunction

   // 16 memory bytes from addr with byte 0 lowest
   function automatic fetch_pkg::line_t mem_line(input fetch_pkg::addr_t addr);
      fetch_pkg::line_t data;
      for (int k = 0; k < fetch_pkg::LINE_BYTES; k++) begin
         data[8*k +: 8] = mem[(addr + k) % MEM_BYTES];
      end
      return data;
   endfunction

   // cache answers 1 to 4 cycles after a request starts
   initial begin : cache_model
      int               delay;
      bit               active;
      fetch_pkg::addr_t req_addr;
      icache_rsp = '0;
      active     = 1'b0;
      delay      = 0;
      req_addr   = '0;
      forever begin
         next_cycle();
         icache_rsp = '0;
         if (!active && icache_req.en) begin
            active   = 1'b1;
            req_addr = icache_req.addr;
            delay    = 1 + ($unsigned($random(seed)) % 4);
         end
         if (active) begin
            if (delay == 0) begin
               icache_rsp = '{ready: 1'b1, data: mem_line(req_addr)};
               active     = 1'b0;
            end else begin
               delay--;
            end
         end
      end
   end

   // accepted lines step by 16 and never outrun free slots
   always @(negedge clk) begin
      if (redirect.strobe) begin
         accepted      = 0;
         expected_addr = linear(redirect.cs, redirect.eip);
      end else if (icache_req.en && icache_rsp.ready) begin
         accepted++;
         check_value(accepted <= NUM_SLOTS + consumed_bytes / 16, 1, "lines fetched ahead");
         check_value(icache_req.addr, expected_addr, "cache request address");
         expected_addr = expected_addr + 32'd16;
      end
   end

   task automatic send_redirect(input fetch_pkg::seg_t cs, input fetch_pkg::addr_t eip);
      redirect       = '{strobe: 1'b1, cs: cs, eip: eip};
      consumed_bytes = 0;
      next_cycle();
      redirect = '0;
      check_value(window.valid, 0, "window valid after redirect");
   endtask

   task automatic check_window(input fetch_pkg::seg_t cs, input fetch_pkg::addr_t eip);
      while (!window.valid) begin
         next_cycle();
      end
      check_value(window.eip, eip, "window eip");
      check_value(window.bytes, mem_line(linear(cs, eip)), "window bytes");
   endtask

   task automatic run_test(input int idx, input test_t t);
      fetch_pkg::addr_t eip_now;
      fetch_pkg::line_t held;
      test_errors = 0;
      if (t.decoy) begin
         send_redirect(t.cs ^ 16'h0f0f, t.eip + 32'h0000_0400);
         // stale request outstanding when the real target arrives
         while (!icache_req.en) begin
            next_cycle();
         end
      end
      send_redirect(t.cs, t.eip);
      eip_now = t.eip;
      check_window(t.cs, eip_now);
      for (int i = 0; i < t.count; i++) begin
         held = window.bytes;
         for (int s = 0; s < t.stall; s++) begin
            next_cycle();
            check_value(window.valid, 1, "window valid during stall");
            check_value(window.bytes, held, "window bytes during stall");
            check_value(window.eip, eip_now, "window eip during stall");
         end
         consume         = '{strobe: 1'b1, len: t.len[i]};
         consumed_bytes += t.len[i];
         next_cycle();
         consume = '0;
         eip_now = eip_now + t.len[i];
         check_window(t.cs, eip_now);
      end
      check_value(window.eip, t.final_eip, "final eip");
      $display("test %0d cs %h eip %h: %0d consumes, %0d errors",
               idx, t.cs, t.eip, t.count, test_errors);
   endtask

   initial begin : main
      int    fd;
      int    f [14];
      string text;
      test_t t;
      arst_n   = 1'b0;
      redirect = '0;
      consume  = '0;
      for (int a = 0; a < MEM_BYTES; a++) begin
         mem[a] = fetch_pkg::byte_t'($random(seed));
      end
      fd = $fopen("testbench/fetch_unit_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open the test file");
         error_count++;
      end else begin
         while ($fgets(text, fd) != 0) begin
            if (text.len() > 1 && text.getc(0) != "#") begin
               if ($sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                           f[9], f[10], f[11], f[12], f[13]) != 14) begin
                  $display("malformed line in the test file: %s", text);
                  error_count++;
               end else begin
                  t.cs        = f[0];
                  t.eip       = f[1];
                  t.stall     = f[2];
                  t.decoy     = f[3];
                  t.count     = f[4];
                  t.final_eip = f[13];
                  for (int k = 0; k < 8; k++) begin
                     t.len[k] = f[5 + k];
                  end
                  tests.push_back(t);
               end
            end
         end
         $fclose(fd);
      end
      if (tests.size() == 0) begin
         $display("no tests were read from the test file");
         error_count++;
      end
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      #5;
      arst_n = 1'b1;
      // idle until the first redirect
      for (int c = 0; c < 20; c++) begin
         next_cycle();
         check_value(icache_req.en, 0, "cache request before any redirect");
         check_value(window.valid, 0, "window valid before any redirect");
      end
      foreach (tests[i]) begin
         run_test(i, tests[i]);
      end
      $display("%0d tests, %0d check errors, %0d assertion failures",
               tests.size(), error_count, DUT.u_checker.assert_fails);
      if (error_count == 0 && DUT.u_checker.assert_fails == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin : watchdog
      wait (loaded);
      #((tests.size() + 1) * 4000);
      $display("timeout, the tests did not finish in time");
      $display("sim failed");
      $finish;
   end

endmodule

/* compile.f */
src/fetch_pkg.sv
src/icache_pkg.sv
src/fetch_line_slot.sv
src/fetch_fill_ctrl.sv
src/fetch_window_align.sv
src/fetch_unit.sv
testbench/fetch_unit_checker.sv
testbench/fetch_unit_tb.sv

/* testbench/fetch_unit_tests.txt */
# cs eip stall decoy count len0 len1 len2 len3 len4 len5 len6 len7 final_eip
# all hex, decoy 1 redirects elsewhere first, unused lengths are 0
0000 00000000 0 0 8 1 2 3 4 5 6 7 8 00000024
0010 00000100 1 0 6 f f f f f f 0 0 0000015a
1234 00005678 2 1 5 3 7 1 f 2 0 0 0 00005694
ffff 0000fff0 0 1 8 f e d c b a 9 8 0001004c
0001 0000000b 3 0 4 5 5 5 5 0 0 0 0 0000001f
0800 12345678 0 1 7 1 1 1 1 1 1 f 0 1234568d
00a5 0000003f 1 0 8 8 8 8 8 8 8 8 8 0000007f
4000 00000ff9 2 1 3 4 9 c 0 0 0 0 0 00001012
0000 fffffffe 0 0 8 f f f f f f f f 00000076
7777 00000001 3 1 8 2 3 4 5 6 7 8 9 0000002d
